// File: verilog/MulDivPkg.sv
package MulDivPkg;

    ////////////////////
    // Widths
    ////////////////////

    // Operand and result width
    localparam int DataWidth = 32;

    // Destination register number
    localparam int TagWidth = 4;

    // Step counter wide enough to hold DataWidth
    localparam int StepCountWidth = $clog2(DataWidth + 1);

    ////////////////////
    // Result buffer
    ////////////////////

    // Entries waiting for the write port, 2 or more
    localparam int FifoDepth = 4;

    ////////////////////
    // Operation encoding
    ////////////////////

    // Unsigned shift-add, low word kept
    localparam logic OpMul = 1'b0;

    // Unsigned restoring division, quotient only
    localparam logic OpDiv = 1'b1;

endpackage

// File: verilog/MulDivControl.sv
`timescale 1ns/1ns

module MulDivControl (
    input  logic CLK,
    input  logic Reset,
    input  logic Start,
    output logic Init,
    output logic Shift,
    output logic Busy,
    output logic Done
);
    import MulDivPkg::*;

    typedef enum logic [1:0] {
        SeqIdle,
        SeqRun,
        SeqFinish
    } SeqState;

    SeqState state;
    SeqState nextState;

    logic [StepCountWidth-1:0] stepCount;
    logic lastStep;

    ////////////////////
    // Step counter
    ////////////////////

    // Final shift happens on the edge leaving this count
    assign lastStep = (stepCount == StepCountWidth'(DataWidth - 1));

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            stepCount <= '0;
        end else if (Init) begin
            stepCount <= '0;
        end else if (Shift) begin
            stepCount <= stepCount + 1'b1;
        end
    end

    ////////////////////
    // Sequencer
    ////////////////////

    always_comb begin
        nextState = state;
        case (state)
            SeqIdle: begin
                if (Start) begin
                    nextState = SeqRun;
                end
            end
            SeqRun: begin
                if (lastStep) begin
                    nextState = SeqFinish;
                end
            end
            SeqFinish: begin
                // One cycle to hand the result over
                nextState = SeqIdle;
            end
            default: begin
                nextState = SeqIdle;
            end
        endcase
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            state <= SeqIdle;
        end else begin
            state <= nextState;
        end
    end

    // Operands load on the same edge that accepts the start
    assign Init = Start && (state == SeqIdle);

    // DataWidth shift cycles, one result bit each
    assign Shift = (state == SeqRun);

    assign Busy = (state != SeqIdle);
    assign Done = (state == SeqFinish);

endmodule

// File: verilog/MulDivUnit.sv
`timescale 1ns/1ns

module MulDivUnit (
    input  logic                           CLK,
    input  logic                           Reset,
    input  logic                           Start,
    input  logic                           MulDivOp,
    input  logic [MulDivPkg::DataWidth-1:0] Operand1,
    input  logic [MulDivPkg::DataWidth-1:0] Operand2,
    input  logic [MulDivPkg::TagWidth-1:0]  Wa3,
    input  logic                           SpaceAvail,
    output logic                           Ready,
    output logic                           Push,
    output logic [MulDivPkg::DataWidth-1:0] PushData,
    output logic [MulDivPkg::TagWidth-1:0]  PushTag
);
    import MulDivPkg::*;

    logic startAccepted;
    logic init;
    logic shift;
    logic busy;
    logic done;

    logic opReg;
    logic isDiv;

    // Upper half accumulates, lower half holds multiplier or quotient bits
    logic [2*DataWidth-1:0] partial;
    // Multiplicand or divisor
    logic [DataWidth-1:0]   operandReg;
    logic [TagWidth-1:0]    tagReg;

    logic [DataWidth:0]     adderA;
    logic [DataWidth:0]     adderB;
    logic [DataWidth+1:0]   adderOut;
    logic                   writeStep;

    ////////////////////
    // Sequencer
    ////////////////////

    // One operation in flight, and the buffer must keep a slot for it
    assign Ready = !busy && SpaceAvail;
    assign startAccepted = Start && Ready;

    MulDivControl control0 (
        .CLK   (CLK),
        .Reset (Reset),
        .Start (startAccepted),
        .Init  (init),
        .Shift (shift),
        .Busy  (busy),
        .Done  (done)
    );

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            opReg <= OpMul;
        end else if (init) begin
            opReg <= MulDivOp;
        end
    end

    assign isDiv = (opReg == OpDiv);

    ////////////////////
    // Shared adder
    ////////////////////

    // Divide works on 2R plus the next dividend bit, which needs one extra bit
    assign adderA = isDiv ? partial[2*DataWidth-1:DataWidth-1]
                          : {1'b0, partial[2*DataWidth-1:DataWidth]};

    // Subtract as add of the inverted divisor with carry in
    assign adderB = isDiv ? ~{1'b0, operandReg} : {1'b0, operandReg};

    assign adderOut = {1'b0, adderA} + {1'b0, adderB} + {{(DataWidth+1){1'b0}}, isDiv};

    // Divide keeps the difference when no borrow, multiply adds on a set low bit
    assign writeStep = isDiv ? adderOut[DataWidth+1] : partial[0];

    ////////////////////
    // Datapath registers
    ////////////////////

    always_ff @(posedge CLK) begin
        if (init) begin
            tagReg <= Wa3;
            if (MulDivOp == OpDiv) begin
                partial    <= {{DataWidth{1'b0}}, Operand1};
                operandReg <= Operand2;
            end else begin
                partial    <= {{DataWidth{1'b0}}, Operand2};
                operandReg <= Operand1;
            end
        end else if (shift) begin
            if (isDiv) begin
                if (writeStep) begin
                    partial <= {adderOut[DataWidth-1:0], partial[DataWidth-2:0], 1'b1};
                end else begin
                    partial <= {partial[2*DataWidth-2:0], 1'b0};
                end
            end else begin
                if (writeStep) begin
                    partial <= {adderOut[DataWidth:0], partial[DataWidth-1:1]};
                end else begin
                    partial <= {1'b0, partial[2*DataWidth-1:1]};
                end
            end
        end
    end

    ////////////////////
    // Result hand-off
    ////////////////////

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            Push <= 1'b0;
        end else begin
            Push <= done;
        end
    end

    // Product low word or quotient
    always_ff @(posedge CLK) begin
        if (done) begin
            PushData <= partial[DataWidth-1:0];
            PushTag  <= tagReg;
        end
    end

endmodule

// File: verilog/ResultFifo.sv
`timescale 1ns/1ns

module ResultFifo #(
    parameter int Depth = MulDivPkg::FifoDepth
) (
    input  logic                           CLK,
    input  logic                           Reset,
    input  logic                           Push,
    input  logic [MulDivPkg::DataWidth-1:0] PushData,
    input  logic [MulDivPkg::TagWidth-1:0]  PushTag,
    input  logic                           Pop,
    output logic [MulDivPkg::DataWidth-1:0] HeadData,
    output logic [MulDivPkg::TagWidth-1:0]  HeadTag,
    output logic                           Empty,
    output logic                           SpaceAvail
);
    import MulDivPkg::*;

    logic [DataWidth-1:0] dataMem [Depth];
    logic [TagWidth-1:0]  tagMem  [Depth];

    logic [$clog2(Depth)-1:0]   wrPtr;
    logic [$clog2(Depth)-1:0]   rdPtr;
    logic [$clog2(Depth+1)-1:0] count;

    logic full;
    logic doPush;
    logic doPop;

    // Wraps for depths that are not a power of two
    function automatic logic [$clog2(Depth)-1:0] nextPtr(input logic [$clog2(Depth)-1:0] ptr);
        if (ptr == ($clog2(Depth))'(Depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    ////////////////////
    // Levels
    ////////////////////

    assign full  = (count == ($clog2(Depth+1))'(Depth));
    assign Empty = (count == '0);

    // Room for the current count, a result about to land, and one more
    assign SpaceAvail = (count < ($clog2(Depth+1))'(Depth - 1));

    assign doPush = Push && !full;
    assign doPop  = Pop && !Empty;

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge CLK) begin
        if (doPush) begin
            dataMem[wrPtr] <= PushData;
            tagMem[wrPtr]  <= PushTag;
        end
    end

    assign HeadData = dataMem[rdPtr];
    assign HeadTag  = tagMem[rdPtr];

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // Simultaneous push and pop leaves the count alone
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: verilog/WritebackMerge.sv
`timescale 1ns/1ns

module WritebackMerge (
    input  logic                           CLK,
    input  logic                           Reset,
    input  logic                           AluWrite,
    input  logic [MulDivPkg::TagWidth-1:0]  AluWa3,
    input  logic [MulDivPkg::DataWidth-1:0] AluData,
    input  logic                           Empty,
    input  logic [MulDivPkg::DataWidth-1:0] HeadData,
    input  logic [MulDivPkg::TagWidth-1:0]  HeadTag,
    output logic                           Pop,
    output logic                           RegWrite,
    output logic [MulDivPkg::TagWidth-1:0]  RegWa3,
    output logic [MulDivPkg::DataWidth-1:0] RegData
);

    ////////////////////
    // Arbitration
    ////////////////////

    // ALU always wins, buffered results take idle slots
    assign Pop = !AluWrite && !Empty;

    ////////////////////
    // Write port
    ////////////////////

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            RegWrite <= 1'b0;
        end else begin
            RegWrite <= AluWrite || Pop;
        end
    end

    always_ff @(posedge CLK) begin
        if (AluWrite) begin
            RegWa3  <= AluWa3;
            RegData <= AluData;
        end else if (Pop) begin
            // Head of the buffer leaves on this edge
            RegWa3  <= HeadTag;
            RegData <= HeadData;
        end
    end

endmodule

// File: verilog/MulDivSubsystem.sv
`timescale 1ns/1ns

module MulDivSubsystem (
    input  logic                           CLK,
    input  logic                           Reset,
    input  logic                           Start,
    input  logic                           MulDivOp,
    input  logic [MulDivPkg::DataWidth-1:0] Operand1,
    input  logic [MulDivPkg::DataWidth-1:0] Operand2,
    input  logic [MulDivPkg::TagWidth-1:0]  Wa3,
    output logic                           Ready,
    input  logic                           AluWrite,
    input  logic [MulDivPkg::TagWidth-1:0]  AluWa3,
    input  logic [MulDivPkg::DataWidth-1:0] AluData,
    output logic                           RegWrite,
    output logic [MulDivPkg::TagWidth-1:0]  RegWa3,
    output logic [MulDivPkg::DataWidth-1:0] RegData
);
    import MulDivPkg::*;

    // Producer to buffer
    logic                 push;
    logic [DataWidth-1:0] pushData;
    logic [TagWidth-1:0]  pushTag;
    logic                 spaceAvail;

    // Buffer to consumer
    logic [DataWidth-1:0] headData;
    logic [TagWidth-1:0]  headTag;
    logic                 empty;
    logic                 pop;

    MulDivUnit unit0 (
        .CLK        (CLK),
        .Reset      (Reset),
        .Start      (Start),
        .MulDivOp   (MulDivOp),
        .Operand1   (Operand1),
        .Operand2   (Operand2),
        .Wa3        (Wa3),
        .SpaceAvail (spaceAvail),
        .Ready      (Ready),
        .Push       (push),
        .PushData   (pushData),
        .PushTag    (pushTag)
    );

    ResultFifo #(
        .Depth (FifoDepth)
    ) fifo0 (
        .CLK        (CLK),
        .Reset      (Reset),
        .Push       (push),
        .PushData   (pushData),
        .PushTag    (pushTag),
        .Pop        (pop),
        .HeadData   (headData),
        .HeadTag    (headTag),
        .Empty      (empty),
        .SpaceAvail (spaceAvail)
    );

    WritebackMerge merge0 (
        .CLK      (CLK),
        .Reset    (Reset),
        .AluWrite (AluWrite),
        .AluWa3   (AluWa3),
        .AluData  (AluData),
        .Empty    (empty),
        .HeadData (headData),
        .HeadTag  (headTag),
        .Pop      (pop),
        .RegWrite (RegWrite),
        .RegWa3   (RegWa3),
        .RegData  (RegData)
    );

endmodule

// File: verification/MulDivModel.svh
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// Low word of the full unsigned product
function automatic logic [MulDivPkg::DataWidth-1:0] productLow(
    input logic [MulDivPkg::DataWidth-1:0] a,
    input logic [MulDivPkg::DataWidth-1:0] b
);
    logic [2*MulDivPkg::DataWidth-1:0] fullProduct;
    fullProduct = {{MulDivPkg::DataWidth{1'b0}}, a} * {{MulDivPkg::DataWidth{1'b0}}, b};
    return fullProduct[MulDivPkg::DataWidth-1:0];
endfunction

// Zero divisor gives all ones, as restoring division never borrows then
function automatic logic [MulDivPkg::DataWidth-1:0] quotientOf(
    input logic [MulDivPkg::DataWidth-1:0] dividend,
    input logic [MulDivPkg::DataWidth-1:0] divisor
);
    if (divisor == '0) begin
        return '1;
    end
    return dividend / divisor;
endfunction

function automatic logic [MulDivPkg::DataWidth-1:0] resultFor(
    input logic                           op,
    input logic [MulDivPkg::DataWidth-1:0] op1,
    input logic [MulDivPkg::DataWidth-1:0] op2
);
    if (op == MulDivPkg::OpDiv) begin
        return quotientOf(op1, op2);
    end
    return productLow(op1, op2);
endfunction

// Queue entry as it should appear on the write port, tag above data
function automatic logic [MulDivPkg::TagWidth+MulDivPkg::DataWidth-1:0] packEntry(
    input logic [MulDivPkg::TagWidth-1:0]  tag,
    input logic [MulDivPkg::DataWidth-1:0] data
);
    return {tag, data};
endfunction

`endif

// File: verification/MulDivTb.sv
`timescale 1ns/1ns

module MulDivTb;
    import MulDivPkg::*;

    `include "MulDivModel.svh"

    localparam int ClockPeriod    = 100;
    localparam int ResetCycles    = 8;
    localparam int RandomOps      = 24;
    localparam int DenseOps       = 6;
    localparam int DenseCycles    = DenseOps * (DataWidth + 2);
    localparam int DrainLimit     = 4 * (DataWidth + 20);
    localparam int WatchdogCycles = ResetCycles + (RandomOps + DenseOps + 4) * (DataWidth + 20);

    logic                 CLK;
    logic                 Reset;
    logic                 start;
    logic                 mulDivOp;
    logic [DataWidth-1:0] operand1;
    logic [DataWidth-1:0] operand2;
    logic [TagWidth-1:0]  wa3;
    logic                 ready;
    logic                 aluWrite;
    logic [TagWidth-1:0]  aluWa3;
    logic [DataWidth-1:0] aluData;
    logic                 regWrite;
    logic [TagWidth-1:0]  regWa3;
    logic [DataWidth-1:0] regData;

    // Expected write-port traffic, tag above data
    logic [TagWidth+DataWidth-1:0] aluQueue[$];
    logic [TagWidth+DataWidth-1:0] resultQueue[$];

    logic        aluDue;
    int          busyLeft;
    int          acceptedCount;
    int          heldOffCount;
    int          drainCycles;
    int unsigned seedValue;

    MulDivSubsystem dut0 (
        .CLK      (CLK),
        .Reset    (Reset),
        .Start    (start),
        .MulDivOp (mulDivOp),
        .Operand1 (operand1),
        .Operand2 (operand2),
        .Wa3      (wa3),
        .Ready    (ready),
        .AluWrite (aluWrite),
        .AluWa3   (aluWa3),
        .AluData  (aluData),
        .RegWrite (regWrite),
        .RegWa3   (regWa3),
        .RegData  (regData)
    );

    always #(ClockPeriod / 2) CLK = ~CLK;

    ////////////////////
    // Failure reporting
    ////////////////////

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic checkEqual(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected) begin
            stopWithFailure($sformatf("mismatch %s: got 0x%0h, expected 0x%0h",
                                      name, actual, expected));
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic driveRandomCycle(input int startPercent, input int aluPercent);
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] b;
        @(posedge CLK);
        // Zero divisor, larger divisor, small divisor or anything
        case ($urandom_range(3, 0))
            0: begin
                a = $urandom();
                b = '0;
            end
            1: begin
                a = $urandom_range(5000, 0);
                b = a + $urandom_range(5000, 1);
            end
            2: begin
                a = $urandom();
                b = $urandom_range(255, 1);
            end
            default: begin
                a = $urandom();
                b = $urandom();
            end
        endcase
        start    <= ($urandom_range(99, 0) < startPercent);
        mulDivOp <= $urandom_range(1, 0);
        operand1 <= a;
        operand2 <= b;
        wa3      <= $urandom_range((1 << TagWidth) - 1, 0);
        aluWrite <= ($urandom_range(99, 0) < aluPercent);
        aluWa3   <= $urandom_range((1 << TagWidth) - 1, 0);
        aluData  <= $urandom();
    endtask

    task automatic driveIdle();
        @(posedge CLK);
        start    <= 1'b0;
        aluWrite <= 1'b0;
    endtask

    ////////////////////
    // Scoreboard
    ////////////////////

    task automatic checkWritePort();
        logic [TagWidth+DataWidth-1:0] expected;
        if (aluDue) begin
            // Strobe from the previous cycle owns the port now
            checkEqual("RegWrite", regWrite, 1'b1);
            expected = aluQueue.pop_front();
            checkEqual("RegWa3", regWa3, expected[TagWidth+DataWidth-1:DataWidth]);
            checkEqual("RegData", regData, expected[DataWidth-1:0]);
        end else if (regWrite) begin
            if (resultQueue.size() == 0) begin
                stopWithFailure("register port wrote a value that no ALU write or result explains");
            end else begin
                expected = resultQueue.pop_front();
                checkEqual("RegWa3", regWa3, expected[TagWidth+DataWidth-1:DataWidth]);
                checkEqual("RegData", regData, expected[DataWidth-1:0]);
            end
        end
    endtask

    task automatic recordInputs();
        if (aluWrite) begin
            aluQueue.push_back(packEntry(aluWa3, aluData));
        end
        aluDue = aluWrite;
        if (busyLeft > 0) begin
            checkEqual("Ready", ready, 1'b0);
            busyLeft--;
        end else if (!ready) begin
            // Idle unit held off by a nearly full buffer
            heldOffCount++;
        end
        if (start && ready) begin
            resultQueue.push_back(packEntry(wa3, resultFor(mulDivOp, operand1, operand2)));
            acceptedCount++;
            busyLeft = DataWidth + 1;
        end
    endtask

    // Outputs settle after the rising edge, inputs stay put until the next one
    always @(negedge CLK) begin
        if (!Reset) begin
            checkWritePort();
            recordInputs();
        end
    end

    initial begin
        #(WatchdogCycles * ClockPeriod);
        stopWithFailure("watchdog expired before all results were written back");
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        seedValue = $urandom(32'h8c2e);
        CLK = 1'b0;
        Reset = 1'b1;
        start = 1'b0;
        mulDivOp = OpMul;
        operand1 = '0;
        operand2 = '0;
        wa3 = '0;
        aluWrite = 1'b0;
        aluWa3 = '0;
        aluData = '0;
        aluDue = 1'b0;
        busyLeft = 0;
        acceptedCount = 0;
        heldOffCount = 0;
        drainCycles = 0;

        repeat (ResetCycles) @(posedge CLK);
        Reset <= 1'b0;
        @(negedge CLK);
        checkEqual("RegWrite", regWrite, 1'b0);
        checkEqual("Ready", ready, 1'b1);

        // Mixed operations, light ALU traffic, many starts while busy
        while (acceptedCount < RandomOps) begin
            driveRandomCycle(40, 25);
        end

        // ALU on every cycle starves the buffer
        heldOffCount = 0;
        repeat (DenseCycles) begin
            driveRandomCycle(100, 100);
        end
        if (heldOffCount == 0) begin
            stopWithFailure("Ready never dropped while ALU traffic filled the result buffer");
        end

        driveIdle();
        while ((resultQueue.size() != 0 || aluQueue.size() != 0) && drainCycles < DrainLimit) begin
            @(posedge CLK);
            drainCycles++;
        end
        // A few quiet cycles catch any stray write
        repeat (4) @(posedge CLK);

        if (resultQueue.size() == 0 && aluQueue.size() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            stopWithFailure("results were still missing after the drain period");
        end
    end

endmodule

// File: sources.f
+incdir+verification
verilog/MulDivPkg.sv
verilog/MulDivControl.sv
verilog/MulDivUnit.sv
verilog/ResultFifo.sv
verilog/WritebackMerge.sv
verilog/MulDivSubsystem.sv
verification/MulDivTb.sv
